//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = playfield_tb
FILELIST = project.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	@! grep -q "TESTBENCH FAILED" $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- hdl/pf_expand.sv
/*
 * expansion of a fetched word group into 8 color indices
 * pixel buffer and its full flag
 */
`default_nettype none
`timescale 1ns/1ps

module pf_expand
    import pf_video_pkg::*, pf_mem_pkg::*;
(
    input  wire logic   clk,                    // pixel clock
    input  wire logic   reset_i,                // sync reset
    input  wire logic   mem_fetch_start_i,      // line start, buffer emptied
    input  wire logic   words_ready_i,          // new group on word inputs
    input  wire bpp_t   pf_bpp_i,               // bits per pixel
    input  wire word_t  word0_i,                // leftmost word
    input  wire word_t  word1_i,
    input  wire word_t  word2_i,
    input  wire word_t  word3_i,
    input  wire logic   buf_take_i,             // scanout copied the buffer
    output color_t [7:0] pixels_buf_o,          // index 7 is leftmost pixel
    output logic        buf_full_o              // buffer waiting for scanout
);

disp_word_u [3:0]   dw;                         // dw[3] is word0
color_t [7:0]       expanded;

always_comb begin
    dw = {word0_i, word1_i, word2_i, word3_i};
    if (pf_bpp_i == BPP_8) begin
        for (int i = 0; i < 4; i++) begin
            expanded[2*i+1] = dw[i].bytes[1];   // high byte first on screen
            expanded[2*i]   = dw[i].bytes[0];
        end
    end else begin
        for (int i = 0; i < 4; i++) begin
            expanded[4+i] = {4'h0, dw[3].nibs[i]};  // word0 nibbles
            expanded[i]   = {4'h0, dw[2].nibs[i]};  // word1 nibbles
        end
    end
end

always_ff @(posedge clk) begin
    if (words_ready_i) begin
        pixels_buf_o <= expanded;
    end
end

always_ff @(posedge clk) begin
    if (reset_i || mem_fetch_start_i) begin
        buf_full_o <= 1'b0;
    end else if (words_ready_i) begin
        buf_full_o <= 1'b1;                     // new group wins over a take
    end else if (buf_take_i) begin
        buf_full_o <= 1'b0;
    end
end

endmodule

`default_nettype wire

//--- hdl/pf_fetch.sv
/*
 * line fetch FSM for the VRAM bus
 * pipelined bitmap word reads into four data words
 * DMA reads outside the fetch window
 */
`default_nettype none
`timescale 1ns/1ps

module pf_fetch
    import pf_video_pkg::*, pf_mem_pkg::*;
(
    input  wire logic   clk,                    // pixel clock
    input  wire logic   reset_i,                // sync reset
    input  wire logic   stall_i,                // freeze for memory contention
    input  wire logic   mem_fetch_i,            // fetch window
    input  wire logic   mem_fetch_start_i,      // strobe at fetch window start
    input  wire logic   end_of_line_i,          // strobe at end of scanline
    input  wire bpp_t   pf_bpp_i,               // bits per pixel
    input  wire addr_t  line_start_i,           // start address of this line
    input  wire logic   buf_full_i,             // pixel buffer still occupied
    output logic        vram_sel_o,             // VRAM read select
    output addr_t       vram_addr_o,            // VRAM word address
    input  wire word_t  vram_data_i,            // VRAM read data
    output logic        words_ready_o,          // data words hold a full group
    output word_t       word0_o,                // leftmost word of group
    output word_t       word1_o,
    output word_t       word2_o,                // 8 bpp only
    output word_t       word3_o,                // 8 bpp only
    input  wire logic   dma_req_i,              // DMA request level
    input  wire addr_t  dma_addr_i,             // DMA word address
    output logic        dma_ack_o,              // DMA data valid pulse
    output word_t       dma_word_o              // DMA read data
);

typedef enum logic [3:0] {
    FETCH_IDLE          = 4'h0,                 // wait for fetch window or DMA
    FETCH_WAIT_DMA      = 4'h1,                 // DMA address in flight
    FETCH_READ_DMA      = 4'h2,                 // DMA data on bus
    FETCH_ADDR_BITMAP   = 4'h4,                 // launch word0 once buffer is free
    FETCH_WAIT_BITMAP   = 4'h5,                 // launch word1, hand off previous group
    FETCH_READ_BITMAP_0 = 4'h8,                 // read states, low bits give word index
    FETCH_READ_BITMAP_1 = 4'h9,
    FETCH_READ_BITMAP_2 = 4'hA,
    FETCH_READ_BITMAP_3 = 4'hB
} fetch_st_t;

fetch_st_t      state, state_next;
addr_t          pf_addr, pf_addr_next;          // next display word to launch
addr_t          addr_next;                      // bus address for next cycle
logic           sel_next;
logic           launch;                         // put pf_addr on bus this cycle
logic           more_words;                     // read state still has a word to launch
logic [1:0]     last_word;                      // index of last word in a group
logic           initial_buf, initial_buf_next;  // first group of line not handed off
logic           ready_next;
logic           dma_ack_next;
word_t [3:0]    words;                          // collected group

always_comb begin
    last_word  = (pf_bpp_i == BPP_8) ? 2'(WORDS_PER_GROUP_8BPP - 1)
                                     : 2'(WORDS_PER_GROUP_4BPP - 1);
    more_words = ({1'b0, state[1:0]} + 3'd2) <= {1'b0, last_word};

    state_next       = state;
    pf_addr_next     = pf_addr;
    addr_next        = vram_addr_o;             // bus address holds between reads
    sel_next         = 1'b0;
    launch           = 1'b0;
    ready_next       = 1'b0;
    initial_buf_next = initial_buf;
    dma_ack_next     = 1'b0;

    case (state)
        FETCH_IDLE: begin
            if (mem_fetch_i) begin
                state_next = FETCH_ADDR_BITMAP; // line fetch wins over DMA
            end else if (dma_req_i && !dma_ack_o) begin
                sel_next   = 1'b1;
                addr_next  = dma_addr_i;
                state_next = FETCH_WAIT_DMA;
            end
        end
        FETCH_WAIT_DMA: begin
            state_next = FETCH_READ_DMA;
        end
        FETCH_READ_DMA: begin
            dma_ack_next = 1'b1;                // ack lands with dma_word_o
            state_next   = FETCH_IDLE;
        end
        FETCH_ADDR_BITMAP: begin
            if (!mem_fetch_i) begin
                state_next = FETCH_IDLE;        // window closed
            end else if (!buf_full_i) begin
                launch     = 1'b1;              // word0
                state_next = FETCH_WAIT_BITMAP;
            end
        end
        FETCH_WAIT_BITMAP: begin
            launch           = 1'b1;            // word1, both modes
            ready_next       = !initial_buf;    // nothing to hand off on first group
            initial_buf_next = 1'b0;
            state_next       = FETCH_READ_BITMAP_0;
        end
        FETCH_READ_BITMAP_0, FETCH_READ_BITMAP_1,
        FETCH_READ_BITMAP_2, FETCH_READ_BITMAP_3: begin
            launch = more_words;                // word2 and word3 in 8 bpp
            if (state[1:0] == last_word) begin
                state_next = FETCH_ADDR_BITMAP;
            end else begin
                state_next = fetch_st_t'(state + 4'd1);
            end
        end
        default: begin
            state_next = FETCH_IDLE;
        end
    endcase

    if (launch) begin
        sel_next     = 1'b1;
        addr_next    = pf_addr;
        pf_addr_next = pf_addr + 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        state         <= FETCH_IDLE;
        vram_sel_o    <= 1'b0;
        vram_addr_o   <= '0;
        pf_addr       <= '0;
        initial_buf   <= 1'b0;
        words_ready_o <= 1'b0;
        dma_ack_o     <= 1'b0;
    end else begin
        if (!stall_i) begin                     // everything here freezes on stall
            state         <= state_next;
            vram_sel_o    <= sel_next;
            vram_addr_o   <= addr_next;
            pf_addr       <= pf_addr_next;
            initial_buf   <= initial_buf_next;
            words_ready_o <= ready_next;
            dma_ack_o     <= dma_ack_next;
        end
        if (mem_fetch_start_i) begin
            initial_buf <= 1'b1;                // prime buffer with first group
            pf_addr     <= line_start_i;
        end
        if (end_of_line_i) begin
            pf_addr     <= line_start_i;        // rewind for repeated lines
        end
    end
end

// data arrives two edges after its address launch
always_ff @(posedge clk) begin
    if (!stall_i && state[3]) begin
        words[state[1:0]] <= vram_data_i;
    end
    if (!stall_i && state == FETCH_READ_DMA) begin
        dma_word_o <= vram_data_i;
    end
end

assign word0_o = words[0];
assign word1_o = words[1];
assign word2_o = words[2];
assign word3_o = words[3];

endmodule

`default_nettype wire

//--- hdl/pf_line_addr.sv
/*
 * display line start address
 * vertical repeat countdown and frame reload
 */
`default_nettype none
`timescale 1ns/1ps

module pf_line_addr
    import pf_video_pkg::*, pf_mem_pkg::*;
(
    input  wire logic       clk,                // pixel clock
    input  wire logic       reset_i,            // sync reset
    input  wire logic       end_of_line_i,      // strobe at end of scanline
    input  wire logic       end_of_frame_i,     // strobe at end of frame
    input  wire logic       pf_blank_i,         // plane disabled
    input  wire addr_t      pf_start_addr_i,    // first line address
    input  wire word_t      pf_line_len_i,      // words per display line
    input  wire repeat_t    pf_v_repeat_i,      // extra copies of each line
    output addr_t           line_start_o        // start address of current line
);

repeat_t v_count;                               // lines left before advancing

always_ff @(posedge clk) begin
    if (reset_i) begin
        line_start_o <= '0;
        v_count      <= '0;
    end else if (pf_blank_i || end_of_frame_i) begin
        line_start_o <= pf_start_addr_i;        // back to top of bitmap
        v_count      <= pf_v_repeat_i;
    end else if (end_of_line_i) begin
        if (v_count == '0) begin
            line_start_o <= line_start_o + pf_line_len_i;   // next bitmap line
            v_count      <= pf_v_repeat_i;                  // restart repeat
        end else begin
            v_count      <= v_count - 1'b1;     // same data again
        end
    end
end

endmodule

`default_nettype wire

//--- hdl/pf_mem_pkg.sv
/*
 * VRAM address and word types
 * display word union with nibble and byte views
 */
`default_nettype none

package pf_mem_pkg;

    typedef logic [15:0] addr_t;                            // VRAM word address
    typedef logic [15:0] word_t;                            // VRAM data word

    // one display word, index 3 / 1 is the leftmost pixel
    typedef union packed {
        logic [3:0][3:0] nibs;                              // 4 bpp view
        logic [1:0][7:0] bytes;                             // 8 bpp view
    } disp_word_u;

    localparam int WORDS_PER_GROUP_8BPP = 4;                // words for 8 pixels at 8 bpp
    localparam int WORDS_PER_GROUP_4BPP = 2;                // words for 8 pixels at 4 bpp

endpackage

`default_nettype wire

//--- hdl/pf_scanout.sv
/*
 * scanout window compares and horizontal repeat
 * 8 pixel shifter with border fill and colorbase XOR
 */
`default_nettype none
`timescale 1ns/1ps

module pf_scanout
    import pf_video_pkg::*;
(
    input  wire logic       clk,                // pixel clock
    input  wire logic       reset_i,            // sync reset
    input  wire hres_t      h_count_i,          // horizontal timing count
    input  wire logic       mem_fetch_i,        // fetch window, gates scanout start
    input  wire logic       mem_fetch_start_i,  // strobe at fetch window start
    input  wire logic       end_of_line_i,      // strobe at end of scanline
    input  wire hres_vis_t  vid_left_i,         // leftmost visible pixel
    input  wire hres_vis_t  vid_right_i,        // right edge plus one
    input  wire color_t     border_color_i,     // color outside the window
    input  wire color_t     pf_colorbase_i,     // XORed into every index
    input  wire repeat_t    pf_h_repeat_i,      // extra clocks per pixel
    input  wire color_t [7:0] pixels_buf_i,     // next 8 pixels
    output logic            buf_take_o,         // buffer copied this cycle
    output color_t          pf_color_index_o    // registered color index
);

logic           scanout;                        // shifter running
logic           scanout_start, scanout_end;
logic           shift;                          // advance to next pixel
hres_t          start_hcount, end_hcount;
repeat_t        h_cnt;                          // repeat countdown
logic [2:0]     col;                            // pixel within group
color_t [7:0]   pixels;                         // index 7 is on output

always_comb begin
    start_hcount  = hres_t'(H_SCANOUT_BEGIN) + vid_left_i;
    end_hcount    = hres_t'(H_SCANOUT_BEGIN) + vid_right_i;
    scanout_start = (h_count_i == start_hcount) && mem_fetch_i;
    scanout_end   = (h_count_i == end_hcount);
    shift         = scanout && (h_cnt == '0);
    buf_take_o    = scanout_start || (shift && col == 3'd7);
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        scanout          <= 1'b0;
        h_cnt            <= '0;
        col              <= '0;
        pixels           <= '0;
        pf_color_index_o <= '0;
    end else begin
        if (shift) begin
            h_cnt <= pf_h_repeat_i;
            col   <= col + 1'b1;
            if (col == 3'd7) begin
                pixels <= pixels_buf_i;                     // next group
            end else begin
                pixels <= {pixels[6:0], border_color_i};    // border fills behind
            end
        end else if (scanout) begin
            h_cnt <= h_cnt - 1'b1;              // hold current pixel
        end

        if (mem_fetch_start_i) begin
            pixels[7] <= border_color_i;        // border even if plane stays blank
        end

        if (scanout_start) begin
            scanout <= 1'b1;
            col     <= '0;
            h_cnt   <= pf_h_repeat_i;
            pixels  <= pixels_buf_i;            // first group of line
        end

        if (scanout_end) begin
            scanout   <= 1'b0;
            pixels[7] <= border_color_i;        // right border
        end

        if (end_of_line_i) begin
            scanout <= 1'b0;
        end

        pf_color_index_o <= pixels[7] ^ pf_colorbase_i;
    end
end

endmodule

`default_nettype wire

//--- hdl/pf_video_pkg.sv
/*
 * video timing constants for the playfield generator
 * horizontal count, color index and repeat types, bpp codes
 */
`default_nettype none

package pf_video_pkg;

    localparam int H_TOTAL         = 96;                    // pixel clocks per line
    localparam int OFFSCREEN_WIDTH = 32;                    // clocks before visible x=0
    localparam int VISIBLE_WIDTH   = 64;                    // visible pixels per line
    localparam int H_SCANOUT_BEGIN = OFFSCREEN_WIDTH - 2;   // scanout pipeline lead

    typedef logic [6:0] hres_t;                             // horizontal count
    typedef logic [6:0] hres_vis_t;                         // visible x position
    typedef logic [7:0] color_t;                            // color index
    typedef logic [1:0] repeat_t;                           // repeat count, 0 = no repeat

    // bits per pixel of the bitmap
    typedef enum logic {
        BPP_4 = 1'b0,                                       // 2 words per 8 pixels
        BPP_8 = 1'b1                                        // 4 words per 8 pixels
    } bpp_t;

endpackage

`default_nettype wire

//--- hdl/playfield_top.sv
/*
 * bitmap playfield generator top level
 * line address, fetch, expansion and scanout blocks
 */
`default_nettype none
`timescale 1ns/1ps

module playfield_top
    import pf_video_pkg::*, pf_mem_pkg::*;
(
    input  wire logic       clk,                // pixel clock
    input  wire logic       reset_i,            // sync reset
    input  wire logic       stall_i,            // memory contention
    input  wire hres_t      h_count_i,          // horizontal timing count
    input  wire logic       mem_fetch_i,        // fetch window
    input  wire logic       mem_fetch_start_i,  // strobe at fetch window start
    input  wire logic       end_of_line_i,
    input  wire logic       end_of_frame_i,
    input  wire color_t     border_color_i,
    input  wire hres_vis_t  vid_left_i,
    input  wire hres_vis_t  vid_right_i,
    output logic            vram_sel_o,         // VRAM bus
    output addr_t           vram_addr_o,
    input  wire word_t      vram_data_i,
    input  wire logic       pf_blank_i,         // plane control
    input  wire addr_t      pf_start_addr_i,
    input  wire word_t      pf_line_len_i,
    input  wire color_t     pf_colorbase_i,
    input  wire bpp_t       pf_bpp_i,
    input  wire repeat_t    pf_h_repeat_i,
    input  wire repeat_t    pf_v_repeat_i,
    output color_t          pf_color_index_o,   // pixel out
    input  wire logic       dma_req_i,          // DMA port
    input  wire addr_t      dma_addr_i,
    output logic            dma_ack_o,
    output word_t           dma_word_o
);

addr_t          line_start;                     // current line address
logic           words_ready;
word_t          word0, word1, word2, word3;     // fetched group
color_t [7:0]   pixels_buf;
logic           buf_full;                       // fetch back-pressure
logic           buf_take;

pf_line_addr u_line_addr (
    .clk             (clk),
    .reset_i         (reset_i),
    .end_of_line_i   (end_of_line_i),
    .end_of_frame_i  (end_of_frame_i),
    .pf_blank_i      (pf_blank_i),
    .pf_start_addr_i (pf_start_addr_i),
    .pf_line_len_i   (pf_line_len_i),
    .pf_v_repeat_i   (pf_v_repeat_i),
    .line_start_o    (line_start)
);

pf_fetch u_fetch (
    .clk               (clk),
    .reset_i           (reset_i),
    .stall_i           (stall_i),
    .mem_fetch_i       (mem_fetch_i),
    .mem_fetch_start_i (mem_fetch_start_i),
    .end_of_line_i     (end_of_line_i),
    .pf_bpp_i          (pf_bpp_i),
    .line_start_i      (line_start),
    .buf_full_i        (buf_full),
    .vram_sel_o        (vram_sel_o),
    .vram_addr_o       (vram_addr_o),
    .vram_data_i       (vram_data_i),
    .words_ready_o     (words_ready),
    .word0_o           (word0),
    .word1_o           (word1),
    .word2_o           (word2),
    .word3_o           (word3),
    .dma_req_i         (dma_req_i),
    .dma_addr_i        (dma_addr_i),
    .dma_ack_o         (dma_ack_o),
    .dma_word_o        (dma_word_o)
);

pf_expand u_expand (
    .clk               (clk),
    .reset_i           (reset_i),
    .mem_fetch_start_i (mem_fetch_start_i),
    .words_ready_i     (words_ready),
    .pf_bpp_i          (pf_bpp_i),
    .word0_i           (word0),
    .word1_i           (word1),
    .word2_i           (word2),
    .word3_i           (word3),
    .buf_take_i        (buf_take),
    .pixels_buf_o      (pixels_buf),
    .buf_full_o        (buf_full)
);

pf_scanout u_scanout (
    .clk               (clk),
    .reset_i           (reset_i),
    .h_count_i         (h_count_i),
    .mem_fetch_i       (mem_fetch_i),
    .mem_fetch_start_i (mem_fetch_start_i),
    .end_of_line_i     (end_of_line_i),
    .vid_left_i        (vid_left_i),
    .vid_right_i       (vid_right_i),
    .border_color_i    (border_color_i),
    .pf_colorbase_i    (pf_colorbase_i),
    .pf_h_repeat_i     (pf_h_repeat_i),
    .pixels_buf_i      (pixels_buf),
    .buf_take_o        (buf_take),
    .pf_color_index_o  (pf_color_index_o)
);

endmodule

`default_nettype wire

//--- project.f
hdl/pf_video_pkg.sv
hdl/pf_mem_pkg.sv
hdl/pf_line_addr.sv
hdl/pf_fetch.sv
hdl/pf_expand.sv
hdl/pf_scanout.sv
hdl/playfield_top.sv
verif/vram_model.sv
verif/playfield_tb.sv

//--- verif/playfield_tb.sv
/*
 * playfield generator testbench
 * clock, reset, line timer and LFSR stimulus
 * concurrent checks of pixels, border, line address and DMA
 */
`default_nettype none
`timescale 1ns/1ps

module playfield_tb
    import pf_video_pkg::*, pf_mem_pkg::*;
();

localparam int LINES     = 6;                   // lines per frame
localparam int FRAMES    = 2;
localparam int FETCH_END = 90;                  // fetch window is h 0..89
localparam int DMA_REQS  = 12;
localparam int TIMEOUT_CYCLES = 4 * (FRAMES * LINES + 2) * H_TOTAL + DMA_REQS * 50 + 100;

logic clk, reset_i, stall_i;
hres_t h_count_i;
logic mem_fetch_i, mem_fetch_start_i, end_of_line_i, end_of_frame_i;
color_t border_color_i, pf_colorbase_i, pf_color_index_o;
hres_vis_t vid_left_i, vid_right_i;
logic vram_sel_o, pf_blank_i, dma_req_i, dma_ack_o;
addr_t vram_addr_o, pf_start_addr_i, dma_addr_i;
word_t vram_data_i, pf_line_len_i, dma_word_o;
bpp_t pf_bpp_i;
repeat_t pf_h_repeat_i, pf_v_repeat_i;

logic rst_chk = 1'b0, pix_chk = 1'b0, dma_chk = 1'b0;  // check enables
addr_t line_s = '0;                             // expected start of current line
color_t exp_color;
logic [31:0] lfsr = 32'hae10;
logic ack_prev = 1'b0;
int err_count = 0, tests_run = 0, tests_failed = 0, ack_count = 0, cycles = 0;

playfield_top DUT (.*);

vram_model u_vram (.clk(clk), .sel_i(vram_sel_o), .addr_i(vram_addr_o), .data_o(vram_data_i));

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

function automatic word_t mem_word(addr_t a);
    return {a[7:0] ^ 8'h5A, a[7:0] + 8'd1};
endfunction

// galois LFSR, one step per bit taken
function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        v    = {v[30:0], lfsr[0]};
    end
    return v;
endfunction

task automatic report_error(string name, logic [15:0] got, logic [15:0] want);
    $display("** Error at %0t: %s = %h, expected %h", $time, name, got, want);
    err_count++;
endtask

task automatic finish_test(string name, int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
        $display("test %s: pass", name);
    end else begin
        tests_failed++;
        $display("test %s: fail, %0d errors", name, err_count - errs_before);
    end
endtask

// expected output from h count, window, repeat and line start
always_comb begin
    int k;
    int x;
    word_t w;
    k = 0;
    x = 0;
    w = '0;
    exp_color = border_color_i;
    if (int'(h_count_i) >= OFFSCREEN_WIDTH + int'(vid_left_i) &&
        int'(h_count_i) <  OFFSCREEN_WIDTH + int'(vid_right_i)) begin
        k = int'(h_count_i) - OFFSCREEN_WIDTH - int'(vid_left_i);
        x = k / (int'(pf_h_repeat_i) + 1);      // pixel held r+1 clocks
        if (pf_bpp_i == BPP_8) begin
            w = mem_word(line_s + addr_t'(x / 2));
            exp_color = (x % 2 == 0) ? w[15:8] : w[7:0];
        end else begin
            w = mem_word(line_s + addr_t'(x / 4));
            exp_color = {4'h0, w[15 - 4 * (x % 4) -: 4]};  // leftmost nibble first
        end
    end
    exp_color = exp_color ^ pf_colorbase_i;
end

assert property (@(posedge clk) disable iff (!rst_chk) !vram_sel_o)
    else report_error("vram_sel_o", 16'($sampled(vram_sel_o)), 16'h0);
assert property (@(posedge clk) disable iff (!rst_chk) !dma_ack_o)
    else report_error("dma_ack_o", 16'($sampled(dma_ack_o)), 16'h0);
assert property (@(posedge clk) disable iff (!rst_chk) pf_color_index_o == 8'h00)
    else report_error("pf_color_index_o", 16'($sampled(pf_color_index_o)), 16'h0);
assert property (@(posedge clk) disable iff (!pix_chk) pf_color_index_o == exp_color)
    else report_error("pf_color_index_o", 16'($sampled(pf_color_index_o)),
                      16'($sampled(exp_color)));
assert property (@(posedge clk) disable iff (!dma_chk)
                 dma_ack_o |-> dma_word_o == mem_word(dma_addr_i))
    else report_error("dma_word_o", $sampled(dma_word_o), mem_word($sampled(dma_addr_i)));

always @(posedge clk) begin
    if (dma_ack_o && !ack_prev) begin
        ack_count++;                            // rising edges only
    end
    ack_prev <= dma_ack_o;
end

always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
        $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end
end

// one scanline, line n of the frame
task automatic run_line(int n, logic last, logic check);
    line_s = pf_start_addr_i + addr_t'((n / (int'(pf_v_repeat_i) + 1)) * int'(pf_line_len_i));
    for (int h = 0; h < H_TOTAL; h++) begin
        @(posedge clk);
        #2;
        h_count_i         = hres_t'(h);
        mem_fetch_i       = (h < FETCH_END);
        mem_fetch_start_i = (h == 0);
        end_of_line_i     = (h == H_TOTAL - 1);
        end_of_frame_i    = last && (h == H_TOTAL - 1);
        pix_chk           = check;
    end
endtask

task automatic idle_cycle();
    @(posedge clk);
    #2;
    mem_fetch_i       = 1'b0;
    mem_fetch_start_i = 1'b0;
    end_of_line_i     = 1'b0;
    end_of_frame_i    = 1'b0;
    pix_chk           = 1'b0;
endtask

task automatic line_test(string name, bpp_t bpp, repeat_t hrep, repeat_t vrep,
                         hres_vis_t left, hres_vis_t right);
    int errs_before;
    errs_before     = err_count;
    pf_bpp_i        = bpp;
    pf_h_repeat_i   = hrep;
    pf_v_repeat_i   = vrep;
    vid_left_i      = left;
    vid_right_i     = right;
    pf_colorbase_i  = color_t'(rand_bits(8));
    border_color_i  = color_t'(rand_bits(8));
    pf_start_addr_i = addr_t'(rand_bits(16));
    pf_line_len_i   = word_t'(rand_bits(16));
    run_line(0, 1'b1, 1'b0);                    // unchecked line, frame end reloads start
    for (int f = 0; f < FRAMES; f++) begin
        for (int n = 0; n < LINES; n++) begin
            run_line(n, n == LINES - 1, 1'b1);
        end
    end
    idle_cycle();
    finish_test(name, errs_before);
endtask

task automatic dma_test();
    int errs_before;
    int acks_before;
    errs_before = err_count;
    acks_before = ack_count;
    dma_chk     = 1'b1;
    for (int i = 0; i < DMA_REQS; i++) begin
        dma_addr_i = addr_t'(rand_bits(16));
        dma_req_i  = 1'b1;
        do begin
            @(posedge clk);
            #2;
            stall_i = (rand_bits(2) == 32'd0);  // stall about one cycle in four
        end while (!dma_ack_o);
        dma_req_i = 1'b0;
        while (dma_ack_o) begin
            @(posedge clk);
            #2;
            stall_i = (rand_bits(2) == 32'd0);
        end
    end
    stall_i = 1'b0;
    @(posedge clk);
    #2;
    dma_chk = 1'b0;
    if (ack_count - acks_before != DMA_REQS) begin
        $display("dma: %0d acknowledges seen for %0d requests", ack_count - acks_before,
                 DMA_REQS);
        err_count++;
    end
    finish_test("dma_reads", errs_before);
endtask

initial begin
    repeat_t hrep;
    repeat_t vrep;
    reset_i = 1'b1;
    stall_i = 1'b0;
    h_count_i = '0;
    mem_fetch_i = 1'b0;
    mem_fetch_start_i = 1'b0;
    end_of_line_i = 1'b0;
    end_of_frame_i = 1'b0;
    border_color_i = '0;
    pf_colorbase_i = '0;
    vid_left_i = '0;
    vid_right_i = '0;
    pf_blank_i = 1'b0;
    pf_start_addr_i = '0;
    pf_line_len_i = '0;
    pf_bpp_i = BPP_4;
    pf_h_repeat_i = '0;
    pf_v_repeat_i = '0;
    dma_req_i = 1'b0;
    dma_addr_i = '0;

    repeat (10) @(posedge clk);
    #2;
    reset_i = 1'b0;
    rst_chk = 1'b1;
    repeat (8) @(posedge clk);
    #2;
    rst_chk = 1'b0;
    finish_test("reset", 0);

    line_test("pixels_8bpp", BPP_8, 2'd0, 2'd0, 7'd4, 7'd56);
    line_test("pixels_4bpp_border", BPP_4, 2'd0, 2'd0, 7'd0, 7'd48);
    hrep = repeat_t'(rand_bits(2));
    if (hrep == 2'd0) begin
        hrep = 2'd1;
    end
    line_test("h_repeat", BPP_8, hrep, 2'd0, 7'd2, 7'd56);
    vrep = repeat_t'(rand_bits(2));
    if (vrep == 2'd0) begin
        vrep = 2'd2;
    end
    line_test("line_address", BPP_4, 2'd0, vrep, 7'd0, 7'd40);
    dma_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (tests_failed == 0) begin
        $display("TESTBENCH PASSED");
    end else begin
        $display("TESTBENCH FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- verif/vram_model.sv
/*
 * behavioral VRAM with one cycle read latency
 * word content is a rule of the address
 */
`default_nettype none
`timescale 1ns/1ps

module vram_model
    import pf_mem_pkg::*;
(
    input  wire logic   clk,                    // pixel clock
    input  wire logic   sel_i,                  // read select
    input  wire addr_t  addr_i,                 // word address
    output word_t       data_o                  // read data, valid after next edge
);

always_ff @(posedge clk) begin
    if (sel_i) begin
        data_o <= {addr_i[7:0] ^ 8'h5A, addr_i[7:0] + 8'd1};   // high byte, low byte
    end
end

endmodule

`default_nettype wire
